/* Bender.yml */
package:
  name: conv_weight_path

sources:
  - src/wl_pkg.sv
  - src/weight_cfg_regs.sv
  - src/weight_load_ctrl.sv
  - src/weight_buffer_ram.sv
  - src/weight_ping_pong.sv
  - src/weight_vector_reader.sv
  - src/conv_weight_path_top.sv
  - target: test
    files:
      - tests/weight_path_assertions.sv
      - tests/tb_conv_weight_path.sv

/* files.f */
src/wl_pkg.sv
src/weight_cfg_regs.sv
src/weight_load_ctrl.sv
src/weight_buffer_ram.sv
src/weight_ping_pong.sv
src/weight_vector_reader.sv
src/conv_weight_path_top.sv
tests/weight_path_assertions.sv
tests/tb_conv_weight_path.sv

/* src/conv_weight_path_top.sv */
module conv_weight_path_top #(
  parameter int WORD_W = 64,
  parameter int BUF_AW = 8
) (
  input  logic              clk,
  input  logic              reset,
  // host registers, four-phase
  input  logic              cfg_req,
  input  logic              cfg_write,
  input  wl_pkg::cfg_addr_t cfg_addr,
  input  wl_pkg::cfg_data_t cfg_wdata,
  output logic              cfg_ack,
  output wl_pkg::cfg_data_t cfg_rdata,
  // layer control
  input  logic              load_start,
  output logic              busy,
  output logic              load_done,
  output wl_pkg::mode_e     mode,          // weight format for the PEs
  // dram read port
  output logic              ddr_rd_en,
  output wl_pkg::ddr_addr_t ddr_rd_addr,
  input  logic              ddr_ready,
  input  logic              ddr_valid,
  input  logic [WORD_W-1:0] ddr_rd_data,
  // PE side
  input  logic              fm_en,
  input  logic              fm_end,
  output logic [WORD_W-1:0] weight_vec,
  output logic              weight_valid
);

  wl_pkg::ddr_addr_t base_addr;
  wl_pkg::count_t    ngrp;
  wl_pkg::count_t    words_per_grp;

  logic              buf_wr_en;
  logic [BUF_AW-1:0] buf_wr_addr;
  logic              buf_rd_en;
  logic [BUF_AW-1:0] buf_rd_addr;
  logic [WORD_W-1:0] buf_rd_data;

  logic              ping_en, ping_wr_en;
  logic [BUF_AW-1:0] ping_addr;
  logic [WORD_W-1:0] ping_wdata, ping_rdata;
  logic              pong_en, pong_wr_en;
  logic [BUF_AW-1:0] pong_addr;
  logic [WORD_W-1:0] pong_wdata, pong_rdata;

  //////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////

  weight_cfg_regs #(.WORD_W(WORD_W)) u_regs (
    .clk, .reset, .cfg_req, .cfg_write, .cfg_addr, .cfg_wdata, .busy,
    .cfg_ack, .cfg_rdata, .base_addr, .mode, .ngrp, .words_per_grp
  );

  weight_load_ctrl #(.BUF_AW(BUF_AW)) u_load (
    .clk, .reset, .load_start, .base_addr, .words_per_grp, .ngrp,
    .ddr_ready, .ddr_valid, .busy, .load_done, .ddr_rd_en, .ddr_rd_addr,
    .buf_wr_en, .buf_wr_addr
  );

  //////////////////////////////////////////////////////////////////////
  // buffers
  //////////////////////////////////////////////////////////////////////

  weight_ping_pong #(.WORD_W(WORD_W), .BUF_AW(BUF_AW)) u_pp (
    .clk, .reset, .load_start, .busy,
    .wr_en(buf_wr_en), .wr_addr(buf_wr_addr), .wr_data(ddr_rd_data),  // dram data direct
    .rd_en(buf_rd_en), .rd_addr(buf_rd_addr), .rd_data(buf_rd_data),
    .ping_en, .ping_wr_en, .ping_addr, .ping_wdata, .ping_rdata,
    .pong_en, .pong_wr_en, .pong_addr, .pong_wdata, .pong_rdata
  );

  weight_buffer_ram #(.WORD_W(WORD_W), .BUF_AW(BUF_AW)) ping_ram (
    .clk, .en(ping_en), .wr_en(ping_wr_en), .addr(ping_addr),
    .wdata(ping_wdata), .rdata(ping_rdata)
  );

  weight_buffer_ram #(.WORD_W(WORD_W), .BUF_AW(BUF_AW)) pong_ram (
    .clk, .en(pong_en), .wr_en(pong_wr_en), .addr(pong_addr),
    .wdata(pong_wdata), .rdata(pong_rdata)
  );

  weight_vector_reader #(.WORD_W(WORD_W), .BUF_AW(BUF_AW)) u_reader (
    .clk, .reset, .load_start, .fm_en, .fm_end, .words_per_grp,
    .rd_data(buf_rd_data), .rd_en(buf_rd_en), .rd_addr(buf_rd_addr),
    .weight_vec, .weight_valid
  );

endmodule

/* src/weight_buffer_ram.sv */
module weight_buffer_ram #(
  parameter int WORD_W = 64,
  parameter int BUF_AW = 8
) (
  input  logic              clk,
  input  logic              en,      // port enable
  input  logic              wr_en,   // write when enabled
  input  logic [BUF_AW-1:0] addr,
  input  logic [WORD_W-1:0] wdata,
  output logic [WORD_W-1:0] rdata    // one cycle after en
);

  localparam int DEPTH = 2 ** BUF_AW;

  logic [WORD_W-1:0] mem [DEPTH];  // one weight word per address

  always_ff @(posedge clk) begin
    if (en) begin
      if (wr_en) begin
        mem[addr] <= wdata;
      end
      rdata <= mem[addr];  // read-first, registered
    end
  end

endmodule

/* src/weight_cfg_regs.sv */
module weight_cfg_regs #(
  parameter int WORD_W = 64
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              cfg_req,        // four-phase request
  input  logic              cfg_write,      // 1 = write, 0 = read
  input  wl_pkg::cfg_addr_t cfg_addr,
  input  wl_pkg::cfg_data_t cfg_wdata,
  input  logic              busy,           // load running, writes dropped
  output logic              cfg_ack,
  output wl_pkg::cfg_data_t cfg_rdata,      // valid while cfg_ack
  output wl_pkg::ddr_addr_t base_addr,
  output wl_pkg::mode_e     mode,
  output wl_pkg::count_t    ngrp,
  output wl_pkg::count_t    words_per_grp   // rounded up words per group
);

  typedef enum logic {
    ack_low  = 1'b0,  // waiting for req
    ack_high = 1'b1   // access done, waiting for req to drop
  } ack_state_e;

  ack_state_e     ack_state;
  wl_pkg::count_t nkk;        // weights per output-channel group
  logic           access;     // first cycle req seen

  // words needed for n weights in the given format
  function automatic wl_pkg::count_t calc_words(input wl_pkg::count_t n,
                                                input wl_pkg::mode_e  m);
    logic [31:0] bits;
    bits = (m == wl_pkg::mode_int8) ? {13'd0, n, 3'd0} : {16'd0, n};
    return wl_pkg::count_t'((bits + WORD_W - 1) / WORD_W);  // ceil
  endfunction

  assign access  = (ack_state == ack_low) && cfg_req;
  assign cfg_ack = (ack_state == ack_high);

  always_ff @(posedge clk) begin
    if (reset) begin
      ack_state <= ack_low;
    end else begin
      case (ack_state)
        ack_low:  if (cfg_req) ack_state <= ack_high;    // ack next cycle
        ack_high: if (!cfg_req) ack_state <= ack_low;    // release next cycle
        default:  ack_state <= ack_low;
      endcase
    end
  end

  // register writes, only while the loader is idle
  always_ff @(posedge clk) begin
    if (reset) begin
      base_addr     <= '0;
      mode          <= wl_pkg::mode_int8;
      nkk           <= '0;
      ngrp          <= '0;
      words_per_grp <= '0;
    end else if (access && cfg_write && !busy) begin
      case (cfg_addr)
        wl_pkg::reg_base: base_addr <= cfg_wdata;
        wl_pkg::reg_mode: begin
          mode          <= wl_pkg::mode_e'(cfg_wdata[0]);
          words_per_grp <= calc_words(nkk, wl_pkg::mode_e'(cfg_wdata[0]));
        end
        wl_pkg::reg_nkk: begin
          nkk           <= cfg_wdata;
          words_per_grp <= calc_words(cfg_wdata, mode);  // rounding done once here
        end
        default: ngrp <= cfg_wdata;  // reg_ngrp
      endcase
    end
  end

  // read data captured at the access, held through ack
  always_ff @(posedge clk) begin
    if (access && !cfg_write) begin
      case (cfg_addr)
        wl_pkg::reg_base: cfg_rdata <= base_addr;
        wl_pkg::reg_mode: cfg_rdata <= {15'd0, mode};
        wl_pkg::reg_nkk:  cfg_rdata <= nkk;
        default:          cfg_rdata <= ngrp;
      endcase
    end
  end

endmodule

/* src/weight_load_ctrl.sv */
module weight_load_ctrl #(
  parameter int BUF_AW = 8
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              load_start,     // one-cycle pulse
  input  wl_pkg::ddr_addr_t base_addr,
  input  wl_pkg::count_t    words_per_grp,
  input  wl_pkg::count_t    ngrp,
  input  logic              ddr_ready,      // dram takes request this cycle
  input  logic              ddr_valid,      // read data returning, in order
  output logic              busy,
  output logic              load_done,      // pulse after last buffer write
  output logic              ddr_rd_en,
  output wl_pkg::ddr_addr_t ddr_rd_addr,
  output logic              buf_wr_en,
  output logic [BUF_AW-1:0] buf_wr_addr
);

  wl_pkg::load_state_e state;
  wl_pkg::count_t      total;        // words in this layer
  wl_pkg::count_t      start_total;  // product at start
  wl_pkg::count_t      req_cnt;      // requests accepted so far
  wl_pkg::count_t      rsp_cnt;      // words written so far
  logic                req_acc;
  logic                last_req;
  logic                last_rsp;

  //////////////////////////////////////////////////////////////////////
  // request and write ports
  //////////////////////////////////////////////////////////////////////

  assign start_total = words_per_grp * ngrp;            // groups times words
  assign busy        = (state != wl_pkg::idle);
  assign ddr_rd_en   = (state == wl_pkg::fetch);
  assign ddr_rd_addr = base_addr + req_cnt;             // base stays put while busy
  assign req_acc     = ddr_rd_en && ddr_ready;
  assign last_req    = req_acc && (req_cnt == total - 1'b1);

  // returned word goes straight into the buffer
  assign buf_wr_en   = ddr_valid && busy;               // stray data in idle dropped
  assign buf_wr_addr = rsp_cnt[BUF_AW-1:0];
  assign last_rsp    = buf_wr_en && (rsp_cnt == total - 1'b1);

  //////////////////////////////////////////////////////////////////////
  // state and counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= wl_pkg::idle;
      total     <= '0;
      req_cnt   <= '0;
      rsp_cnt   <= '0;
      load_done <= 1'b0;
    end else begin
      load_done <= 1'b0;

      case (state)
        wl_pkg::idle: begin
          if (load_start) begin
            total   <= start_total;
            req_cnt <= '0;
            rsp_cnt <= '0;
            if (start_total == '0) begin
              load_done <= 1'b1;               // empty layer, nothing to fetch
            end else begin
              state <= wl_pkg::fetch;
            end
          end
        end

        wl_pkg::fetch: begin
          if (req_acc) req_cnt <= req_cnt + 1'b1;  // requests run ahead of data
          if (last_req) state <= wl_pkg::drain;
        end

        default: ;  // drain, wait for the last responses
      endcase

      if (buf_wr_en) rsp_cnt <= rsp_cnt + 1'b1;

      // last word written this cycle, done flag next
      if (last_rsp) begin
        state     <= wl_pkg::idle;
        load_done <= 1'b1;
      end
    end
  end

endmodule

/* src/weight_ping_pong.sv */
module weight_ping_pong #(
  parameter int WORD_W = 64,
  parameter int BUF_AW = 8
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              load_start,
  input  logic              busy,         // start ignored while set
  input  logic              wr_en,        // from load controller
  input  logic [BUF_AW-1:0] wr_addr,
  input  logic [WORD_W-1:0] wr_data,
  input  logic              rd_en,        // from vector reader
  input  logic [BUF_AW-1:0] rd_addr,
  output logic [WORD_W-1:0] rd_data,
  // ping ram port
  output logic              ping_en,
  output logic              ping_wr_en,
  output logic [BUF_AW-1:0] ping_addr,
  output logic [WORD_W-1:0] ping_wdata,
  input  logic [WORD_W-1:0] ping_rdata,
  // pong ram port
  output logic              pong_en,
  output logic              pong_wr_en,
  output logic [BUF_AW-1:0] pong_addr,
  output logic [WORD_W-1:0] pong_wdata,
  input  logic [WORD_W-1:0] pong_rdata
);

  logic bank;    // 0: write ping, read pong; 1: write pong, read ping
  logic bank_q;  // bank of the read issued last cycle

  always_ff @(posedge clk) begin
    if (reset) begin
      bank   <= 1'b0;
      bank_q <= 1'b0;
    end else begin
      if (load_start && !busy) bank <= ~bank;  // accepted start swaps halves
      bank_q <= bank;
    end
  end

  // writer on bank, reader on the other half
  assign ping_en    = bank ? rd_en : wr_en;
  assign ping_wr_en = !bank && wr_en;
  assign ping_addr  = bank ? rd_addr : wr_addr;
  assign ping_wdata = wr_data;

  assign pong_en    = bank ? wr_en : rd_en;
  assign pong_wr_en = bank && wr_en;
  assign pong_addr  = bank ? wr_addr : rd_addr;
  assign pong_wdata = wr_data;

  // read data follows the bank at issue time, not the current one
  assign rd_data = bank_q ? ping_rdata : pong_rdata;

endmodule

/* src/weight_vector_reader.sv */
module weight_vector_reader #(
  parameter int WORD_W = 64,
  parameter int BUF_AW = 8
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              load_start,    // new layer, restart at group 0
  input  logic              fm_en,         // weight word needed
  input  logic              fm_end,        // last word of the group
  input  wl_pkg::count_t    words_per_grp,
  input  logic [WORD_W-1:0] rd_data,       // ram output, one cycle later
  output logic              rd_en,
  output logic [BUF_AW-1:0] rd_addr,
  output logic [WORD_W-1:0] weight_vec,    // to the PE array
  output logic              weight_valid
);

  wl_pkg::count_t grp_base;  // first word of current group
  wl_pkg::count_t offset;    // word within group
  wl_pkg::count_t rd_word;

  //////////////////////////////////////////////////////////////////////
  // address stepping
  //////////////////////////////////////////////////////////////////////

  assign rd_word = grp_base + offset;
  assign rd_addr = rd_word[BUF_AW-1:0];
  assign rd_en   = fm_en;  // one read per fm_en cycle

  always_ff @(posedge clk) begin
    if (reset) begin
      grp_base <= '0;
      offset   <= '0;
    end else if (load_start) begin
      grp_base <= '0;  // next layer starts at word 0
      offset   <= '0;
    end else if (fm_en) begin
      if (fm_end) begin
        offset   <= '0;
        grp_base <= grp_base + words_per_grp;  // step to next group
      end else begin
        offset <= offset + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output stage, matches ram latency
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      weight_valid <= 1'b0;
    end else begin
      weight_valid <= fm_en;  // back-to-back reads pipeline
    end
  end

  assign weight_vec = weight_valid ? rd_data : '0;  // zeros between vectors

endmodule

/* src/wl_pkg.sv */
package wl_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths with a meaning
  //////////////////////////////////////////////////////////////////////

  typedef logic [15:0] ddr_addr_t;  // dram word address
  typedef logic [15:0] count_t;     // word / channel counts
  typedef logic [1:0]  cfg_addr_t;  // host register index
  typedef logic [15:0] cfg_data_t;  // host register data

  //////////////////////////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////////////////////////

  // weight format of a layer
  typedef enum logic {
    mode_int8 = 1'b0,  // WORD_W/8 weights per word
    mode_bin  = 1'b1   // WORD_W weights per word
  } mode_e;

  // load controller
  typedef enum logic [1:0] {
    idle  = 2'd0,  // waiting for start
    fetch = 2'd1,  // dram requests going out
    drain = 2'd2   // all requested, waiting for data
  } load_state_e;

  //////////////////////////////////////////////////////////////////////
  // host register map
  //////////////////////////////////////////////////////////////////////

  localparam cfg_addr_t reg_base = 2'd0;  // layer base in dram
  localparam cfg_addr_t reg_mode = 2'd1;  // mode_e in bit 0
  localparam cfg_addr_t reg_nkk  = 2'd2;  // nif * k * k
  localparam cfg_addr_t reg_ngrp = 2'd3;  // output channel groups

endpackage

/* tests/tb_conv_weight_path.sv */
module tb_conv_weight_path;

  localparam int WORD_W     = 64;
  localparam int BUF_AW     = 8;
  localparam int MAX_CYCLES = 6 * 2000;  // six tests, generous per test

  logic clk = 1'b0, reset = 1'b1;
  logic cfg_req, cfg_write, cfg_ack, load_start, busy, load_done;
  wl_pkg::cfg_addr_t cfg_addr;
  wl_pkg::cfg_data_t cfg_wdata, cfg_rdata, rd_val;
  wl_pkg::mode_e mode;
  logic ddr_rd_en, ddr_ready, ddr_valid, fm_en, fm_end, weight_valid;
  wl_pkg::ddr_addr_t ddr_rd_addr;
  logic [WORD_W-1:0] ddr_rd_data, weight_vec;

  logic [WORD_W-1:0] dram [0:1023];
  logic [WORD_W-1:0] exp_q [$];          // expected weight vectors
  wl_pkg::ddr_addr_t req_q [$];          // accepted dram requests
  logic [9:0] pend_addr [$];
  int pend_due [$];
  int seed = 82055, cyc = 0, last_due = 0, delay, due;
  int errors = 0, checks = 0, done_cnt = 0;
  int p_base, p_wpg, p_ngrp;             // layer streamed on next swap
  logic bp_on = 1'b0, fm_en_d = 1'b0;

  conv_weight_path_top #(.WORD_W(WORD_W), .BUF_AW(BUF_AW)) UUT (.*);

  bind conv_weight_path_top weight_path_assertions u_checks (
    .clk, .reset, .cfg_req, .cfg_ack, .ping_wr_en, .pong_wr_en,
    .load_start, .ddr_rd_en, .busy, .load_done
  );

  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////
  // dram model, in order, 1 to 4 cycles latency
  ////////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    ddr_valid <= 1'b0;
    if (pend_due.size() > 0 && pend_due[0] <= cyc) begin
      ddr_valid   <= 1'b1;
      ddr_rd_data <= dram[pend_addr.pop_front()];
      void'(pend_due.pop_front());
    end
    if (!reset && ddr_rd_en && ddr_ready) begin
      delay = 1 + ($random(seed) & 3);
      due   = cyc + delay;
      if (due <= last_due) due = last_due + 1;  // keep order
      last_due = due;
      pend_due.push_back(due);
      pend_addr.push_back(ddr_rd_addr[9:0]);
      req_q.push_back(ddr_rd_addr);
    end
    ddr_ready <= bp_on ? $random(seed) : 1'b1;
    cyc++;
  end

  // vector monitor, valid one cycle after fm_en
  always @(posedge clk) begin
    if (!reset) begin
      assert (weight_valid == fm_en_d)
        else begin
          $display("Fail %0t: weight_valid not aligned to fm_en", $time);
          errors++;
        end
      if (load_done) done_cnt++;  // pulses per load
      if (weight_valid) begin
        checks++;
        if (exp_q.size() == 0) begin
          $display("weight vector arrived with none expected at %0t", $time);
          errors++;
        end else begin
          assert (weight_vec == exp_q[0])
            else begin
              $display("Fail %0t: weight_vec %h exp %h", $time, weight_vec, exp_q[0]);
              errors++;
            end
          void'(exp_q.pop_front());
        end
      end
    end
    fm_en_d = reset ? 1'b0 : fm_en;
  end

  task automatic cfg_access(input logic wr, input wl_pkg::cfg_addr_t a,
                            input wl_pkg::cfg_data_t d, output wl_pkg::cfg_data_t q);
    int n;
    n = 0;
    @(posedge clk);
    cfg_req   <= 1'b1;
    cfg_write <= wr;
    cfg_addr  <= a;
    cfg_wdata <= d;
    do begin
      @(posedge clk);
      n++;
    end while (!cfg_ack && n < 100);
    if (n >= 100) begin
      $display("no cfg_ack for request at %0t", $time);
      errors++;
    end
    q = cfg_rdata;
    cfg_req <= 1'b0;
    do begin
      @(posedge clk);
      n++;
    end while (cfg_ack && n < 200);
  endtask

  task automatic pulse_start();
    @(posedge clk) load_start <= 1'b1;
    @(posedge clk) load_start <= 1'b0;
  endtask

  task automatic wait_done();
    int n;
    for (n = 0; n < 3000; n++) begin
      @(posedge clk);
      if (load_done) break;
    end
    if (n == 3000) begin
      $display("load_done never came, time %0t", $time);
      errors++;
    end else begin
      checks++;
      assert (!busy)
        else begin
          $display("Fail %0t: busy high with load_done", $time);
          errors++;
        end
      repeat (2) @(posedge clk);  // room for a second pulse to show
      assert (done_cnt == 1)
        else begin
          $display("Fail %0t: %0d load_done pulses, exp 1", $time, done_cnt);
          errors++;
        end
    end
  endtask

  task automatic stream_layer(input int base, input int wpg, input int ng);
    for (int g = 0; g < ng; g++) begin
      for (int o = 0; o < wpg; o++) begin
        @(posedge clk);
        fm_en <= 1'b1;
        fm_end <= (o == wpg - 1);
        exp_q.push_back(dram[(base + g * wpg + o) % 1024]);
      end
    end
    @(posedge clk);
    fm_en  <= 1'b0;
    fm_end <= 1'b0;
    repeat (3) @(posedge clk);  // drain pipeline
  endtask

  task automatic check_requests(input int base, input int total);
    checks++;
    assert (req_q.size() == total)
      else begin
        $display("Fail %0t: %0d requests, exp %0d", $time, req_q.size(), total);
        errors++;
      end
    for (int i = 0; i < req_q.size(); i++)
      assert (req_q[i] == wl_pkg::ddr_addr_t'(base + i))
        else begin
          $display("Fail %0t: request %0d addr %0d", $time, i, req_q[i]);
          errors++;
        end
  endtask

  function automatic int words_for(input int md, input int nkk);
    return md ? (nkk + WORD_W - 1) / WORD_W : (nkk * 8 + WORD_W - 1) / WORD_W;  // ceil
  endfunction

  task automatic set_layer(input int base, input int md, input int nkk, input int ng);
    cfg_access(1'b1, wl_pkg::reg_base, wl_pkg::cfg_data_t'(base), rd_val);
    cfg_access(1'b1, wl_pkg::reg_mode, wl_pkg::cfg_data_t'(md), rd_val);
    cfg_access(1'b1, wl_pkg::reg_nkk, wl_pkg::cfg_data_t'(nkk), rd_val);
    cfg_access(1'b1, wl_pkg::reg_ngrp, wl_pkg::cfg_data_t'(ng), rd_val);
  endtask

  // load one layer, optionally streaming the previous one meanwhile
  // the reader steps groups by the programmed words_per_grp, so the
  // streamed layer and the loading one share their group size
  task automatic load_layer(input int base, input int md, input int nkk, input int ng,
                            input logic bp, input logic stream_prev);
    int total;
    total = words_for(md, nkk) * ng;
    set_layer(base, md, nkk, ng);
    checks++;
    assert (mode == wl_pkg::mode_e'(md[0]))
      else begin
        $display("Fail %0t: mode output %0d exp %0d", $time, mode, md);
        errors++;
      end
    req_q.delete();
    done_cnt = 0;
    bp_on <= bp;
    pulse_start();
    if (stream_prev) begin
      fork
        stream_layer(p_base, p_wpg, p_ngrp);
        wait_done();
      join
    end else begin
      wait_done();
    end
    bp_on <= 1'b0;
    check_requests(base, total);
    p_base = base;
    p_wpg  = words_for(md, nkk);
    p_ngrp = ng;
  endtask

  ////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////

  task automatic register_readback();
    wl_pkg::cfg_data_t vals [4];
    vals = '{16'h1234, 16'h0001, 16'd77, 16'd5};
    for (int i = 0; i < 4; i++)
      cfg_access(1'b1, wl_pkg::cfg_addr_t'(i), vals[i], rd_val);
    for (int i = 0; i < 4; i++) begin
      cfg_access(1'b0, wl_pkg::cfg_addr_t'(i), 16'h0, rd_val);
      checks++;
      assert (rd_val == vals[i])
        else begin
          $display("Fail %0t: reg %0d read %h", $time, i, rd_val);
          errors++;
        end
    end
    checks++;
    assert (mode == wl_pkg::mode_bin)  // bit 0 of the mode write
      else begin
        $display("Fail %0t: mode output %0d exp 1", $time, mode);
        errors++;
      end
  endtask

  task automatic int8_load();
    load_layer(16, 0, 20, 3, 1'b0, 1'b0);     // 3 words per group, 9 words
  endtask

  task automatic ping_pong_stream();
    load_layer(100, 0, 24, 2, 1'b0, 1'b1);    // layer B in, layer A out
    load_layer(300, 0, 18, 2, 1'b0, 1'b1);    // restart, layer B out
  endtask

  task automatic back_pressure_load();
    load_layer(400, 0, 20, 3, 1'b1, 1'b1);    // same shape as the int8 load
  endtask

  task automatic binary_load();
    load_layer(500, 1, 130, 2, 1'b0, 1'b1);   // 3 words per group
  endtask

  task automatic start_while_busy();
    int total;
    total = words_for(0, 24) * 10;
    set_layer(700, 0, 24, 10);             // 30 words, long enough to stay busy
    req_q.delete();
    done_cnt = 0;
    pulse_start();
    repeat (3) @(posedge clk);
    pulse_start();                         // ignored, also clears reader base
    cfg_access(1'b1, wl_pkg::reg_base, 16'd999, rd_val);  // dropped while busy
    wait_done();
    check_requests(700, total);
    cfg_access(1'b0, wl_pkg::reg_base, 16'd0, rd_val);
    checks++;
    assert (rd_val == 16'd700)
      else begin
        $display("Fail %0t: base changed to %0d during busy", $time, rd_val);
        errors++;
      end
    stream_layer(p_base, p_wpg, p_ngrp);   // bank not flipped, binary layer still here
  endtask

  initial begin
    cfg_req     = 1'b0;
    cfg_write   = 1'b0;
    cfg_addr    = '0;
    cfg_wdata   = '0;
    load_start  = 1'b0;
    ddr_ready   = 1'b1;
    ddr_valid   = 1'b0;
    ddr_rd_data = '0;
    fm_en       = 1'b0;
    fm_end      = 1'b0;
    for (int i = 0; i < 1024; i++)
      dram[i] = {$random(seed), $random(seed)};
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    register_readback();
    int8_load();
    ping_pong_stream();
    back_pressure_load();
    binary_load();
    start_while_busy();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  initial begin
    #(MAX_CYCLES * 4);
    $display("watchdog expired, run did not finish");
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* tests/weight_path_assertions.sv */
module weight_path_assertions (
  input logic clk,
  input logic reset,
  input logic cfg_req,
  input logic cfg_ack,
  input logic ping_wr_en,
  input logic pong_wr_en,
  input logic load_start,
  input logic ddr_rd_en,
  input logic busy,
  input logic load_done
);

  logic wrote_ping;  // ping written during this load
  logic wrote_pong;  // pong written during this load

  always_ff @(posedge clk) begin
    if (reset || !busy) begin
      wrote_ping <= 1'b0;
      wrote_pong <= 1'b0;
    end else begin
      if (ping_wr_en) wrote_ping <= 1'b1;
      if (pong_wr_en) wrote_pong <= 1'b1;
    end
  end

  // ack only answers a live request
  ack_follows_req: assert property (@(posedge clk) disable iff (reset)
    $rose(cfg_ack) |-> cfg_req)
    else $error("cfg_ack rose without cfg_req");

  // one load fills one bank only
  single_bank_write: assert property (@(posedge clk) disable iff (reset)
    !((ping_wr_en || wrote_ping) && (pong_wr_en || wrote_pong)))
    else $error("ping and pong written in the same load");

  // requests only follow a start pulse
  ddr_quiet_when_idle: assert property (@(posedge clk) disable iff (reset)
    !busy |=> !ddr_rd_en || $past(load_start))
    else $error("ddr_rd_en high while not busy");

  done_is_pulse: assert property (@(posedge clk) disable iff (reset)
    load_done |=> !load_done)
    else $error("load_done longer than one cycle");

endmodule
